/* build.f */
core_pkg.sv
i2s_if.sv
mode_select.sv
bridge_read_mux.sv
audio_clock_gen.sv
i2s_frame.sv
core_top.sv
core_assertions.sv
tb_core.sv

/* tb_core.sv */
// testbench for core_top, single clk_74a domain
// expected values come from small reference models run on every rising edge
// inputs change and outputs are compared on the falling edge
`timescale 1ns/1ns
`default_nettype none

module tb_core;

    import core_pkg::*;

    // cycle budgets per test summed by the watchdog
    localparam int RESET_CYCLES   = 8;
    localparam int MCLK_CYCLES    = 20000;
    localparam int FRAME_CYCLES   = 4000;
    localparam int MODE_STEPS     = 300;
    localparam int READ_STEPS     = 200;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + MCLK_CYCLES + FRAME_CYCLES
                                  + MODE_STEPS * 4 + READ_STEPS * 4 + 1000;

    logic        clk_74a;
    logic        rst;
    logic [31:0] cont1_key;
    logic [31:0] bridge_addr;
    logic        bridge_rd;
    logic [31:0] cmd_rd_data;
    logic [31:0] bridge_rd_data;
    mode_t       mode;
    logic        audio_mclk;
    logic        audio_sclk;
    logic        audio_lrck;
    logic        audio_dac;

    // reference model state updated on the rising edge
    logic               model_valid = 1'b0;
    logic [ACCUM_W-1:0] m_acc;
    logic [ACCUM_W:0]   acc_res;
    logic               m_mclk;
    mode_t              m_mode;
    logic               m_key_prev;
    logic [31:0]        m_rd_data;

    // observed edge counters and results
    logic prev_mclk = 1'b0;
    logic prev_sclk = 1'b0;
    logic prev_lrck = 1'b0;
    int   mclk_rises = 0;
    int   sclk_falls = 0;
    int   mclk_toggles = 0;
    int   sclk_changes = 0;
    int   lrck_changes = 0;
    int   errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;

    core_top #(
        .MCLK_STEP    (MCLK_STEP),
        .MCLK_MODULUS (MCLK_MODULUS),
        .SLOT_BITS    (SLOT_BITS)
    ) dut (
        .clk_74a        (clk_74a),
        .rst            (rst),
        .cont1_key      (cont1_key),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .cmd_rd_data    (cmd_rd_data),
        .bridge_rd_data (bridge_rd_data),
        .mode           (mode),
        .audio_mclk     (audio_mclk),
        .audio_sclk     (audio_sclk),
        .audio_lrck     (audio_lrck),
        .audio_dac      (audio_dac)
    );

    initial begin
        clk_74a = 1'b0;
        forever #50 clk_74a = ~clk_74a;
    end

    ////////////////////////////////////////////////////////////
    // reference functions

    // returns {tick, next accumulator}
    function automatic logic [ACCUM_W:0] accum_next(input logic [ACCUM_W-1:0] acc);
        int sum;
        sum = int'(acc) + int'(MCLK_STEP);
        if (sum >= int'(MCLK_MODULUS)) begin
            return {1'b1, ACCUM_W'(sum - int'(MCLK_MODULUS))};
        end
        return {1'b0, ACCUM_W'(sum)};
    endfunction

    // one step per key press with 3 wrapping to 0
    function automatic mode_t mode_next(input mode_t cur, input logic key, input logic key_prev);
        if (key && !key_prev) begin
            return mode_t'((int'(cur) + 1) % 4);
        end
        return cur;
    endfunction

    // top address byte picks the device
    function automatic logic [31:0] read_expect(input logic [31:0] addr, input mode_t m,
                                                input logic [31:0] cmd);
        if (addr[31:24] == REGION_MODE) begin
            return {30'd0, m};
        end else if (addr[31:24] == REGION_CMD) begin
            return cmd;
        end
        return 32'd0;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // waits for a rising edge so the counters are settled
    task automatic close_test(input string name, input int err_start);
        @(posedge clk_74a);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_run, name, errors - err_start);
    endtask

    ////////////////////////////////////////////////////////////
    // model and compare processes

    always @(posedge clk_74a) begin
        if (rst) begin
            m_acc       = '0;
            m_mclk      = 1'b0;
            m_mode      = '0;
            m_key_prev  = 1'b0;
            m_rd_data   = '0;
            model_valid = 1'b1;
        end else begin
            // read uses the mode held before this edge
            if (bridge_rd) begin
                m_rd_data = read_expect(bridge_addr, m_mode, cmd_rd_data);
            end
            m_mode     = mode_next(m_mode, cont1_key[0], m_key_prev);
            m_key_prev = cont1_key[0];
            acc_res    = accum_next(m_acc);
            m_acc      = acc_res[ACCUM_W-1:0];
            if (acc_res[ACCUM_W]) begin
                m_mclk = ~m_mclk;
            end
        end
    end

    always @(negedge clk_74a) begin
        if (model_valid) begin
            check_equal("mode", 32'(mode), 32'(m_mode));
            check_equal("bridge_rd_data", bridge_rd_data, m_rd_data);
            check_equal("audio_mclk", 32'(audio_mclk), 32'(m_mclk));
            check_equal("audio_dac", 32'(audio_dac), 32'd0);
            if (audio_mclk != prev_mclk) begin
                mclk_toggles++;
            end
            if (audio_mclk && !prev_mclk) begin
                mclk_rises++;
            end
            // sclk moves on every second mclk rise
            if (audio_sclk != prev_sclk) begin
                check_equal("mclk rises per sclk change", mclk_rises, 32'd2);
                mclk_rises = 0;
                sclk_changes++;
            end
            if (!audio_sclk && prev_sclk) begin
                sclk_falls++;
            end
            // lrck follows one cycle after the last sclk fall of a slot
            if (audio_lrck != prev_lrck) begin
                check_equal("sclk falls per lrck change", sclk_falls, SLOT_BITS);
                sclk_falls = 0;
                lrck_changes++;
            end
            prev_mclk = audio_mclk;
            prev_sclk = audio_sclk;
            prev_lrck = audio_lrck;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        int          err_start;
        int          seen;
        int          seen_sclk;
        int          hold;
        logic        key0;
        logic [7:0]  region;
        logic [31:0] rnd;

        void'($urandom(32'he850_80df));
        rst         = 1'b1;
        cont1_key   = '0;
        bridge_addr = '0;
        bridge_rd   = 1'b0;
        cmd_rd_data = '0;
        repeat (RESET_CYCLES) @(negedge clk_74a);
        rst = 1'b0;

        // reset values before the first rising edge out of reset
        err_start = errors;
        check_equal("mode after reset", 32'(mode), 32'd0);
        check_equal("bridge_rd_data after reset", bridge_rd_data, 32'd0);
        check_equal("audio_mclk after reset", 32'(audio_mclk), 32'd0);
        check_equal("audio_sclk after reset", 32'(audio_sclk), 32'd0);
        check_equal("audio_lrck after reset", 32'(audio_lrck), 32'd0);
        check_equal("audio_dac after reset", 32'(audio_dac), 32'd0);
        close_test("reset state", err_start);

        // mclk against the accumulator model with idle inputs
        err_start = errors;
        seen      = mclk_toggles;
        repeat (MCLK_CYCLES) @(negedge clk_74a);
        @(posedge clk_74a);
        check_equal("mclk toggled at all", 32'(mclk_toggles > seen), 32'd1);
        close_test("mclk toggles", err_start);

        // sclk and lrck ratios are checked on every sample
        err_start = errors;
        seen      = lrck_changes;
        seen_sclk = sclk_changes;
        repeat (FRAME_CYCLES) @(negedge clk_74a);
        @(posedge clk_74a);
        check_equal("sclk toggled at all", 32'(sclk_changes > seen_sclk), 32'd1);
        check_equal("lrck toggled at all", 32'(lrck_changes > seen), 32'd1);
        close_test("sclk and lrck", err_start);

        // random presses and holds on bit 0 with noise on the other bits
        err_start = errors;
        for (int i = 0; i < MODE_STEPS; i++) begin
            key0 = 1'($urandom_range(0, 1));
            hold = $urandom_range(1, 4);
            repeat (hold) begin
                @(negedge clk_74a);
                rnd       = $urandom();
                cont1_key = {rnd[31:1], key0};
            end
        end
        close_test("mode counting", err_start);

        // reads across the three kinds of region with held data in the gaps
        err_start = errors;
        for (int i = 0; i < READ_STEPS; i++) begin
            case ($urandom_range(0, 2))
                0: region = REGION_MODE;
                1: region = REGION_CMD;
                default: begin
                    do begin
                        region = 8'($urandom_range(0, 255));
                    end while (region == REGION_MODE || region == REGION_CMD);
                end
            endcase
            @(negedge clk_74a);
            rnd         = $urandom();
            bridge_addr = {region, rnd[23:0]};
            cmd_rd_data = $urandom();
            bridge_rd   = 1'b1;
            // keep mode moving so the readback varies
            cont1_key   = {31'd0, 1'($urandom_range(0, 1))};
            hold        = $urandom_range(1, 3);
            repeat (hold) begin
                @(negedge clk_74a);
                bridge_rd   = 1'b0;
                bridge_addr = $urandom();
                cmd_rd_data = $urandom();
            end
        end
        close_test("bridge reads", err_start);

        // failures of the bound I2S checker
        errors += dut.u_frame.u_assert.fail_count;

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog over the summed budgets
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_74a);
        $display("run timed out after %0d cycles, tests did not complete", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* core_assertions.sv */
// I2S framing checks bound into every i2s_frame instance
// sclk_fall comes from audio_clock_gen through the shared i2s bundle
`timescale 1ns/1ns
`default_nettype none

module core_assertions (
    input wire clk_74a,
    input wire rst,
    input wire sclk_fall,
    input wire lrck,
    input wire dac
);

    // count of failed assertions
    int fail_count = 0;

    // strobe never stretches
    sclk_fall_one_cycle: assert property (@(posedge clk_74a) disable iff (rst)
        sclk_fall |=> !sclk_fall)
        else begin
            fail_count++;
            $error("sclk_fall stayed high for more than one cycle");
        end

    // channel switch only on an sclk falling strobe
    lrck_on_sclk_fall: assert property (@(posedge clk_74a) disable iff (rst)
        !$stable(lrck) |-> $past(sclk_fall))
        else begin
            fail_count++;
            $error("lrck changed without sclk_fall");
        end

    // silence only
    dac_low: assert property (@(posedge clk_74a) disable iff (rst) !dac)
        else begin
            fail_count++;
            $error("dac went high");
        end

endmodule

bind i2s_frame core_assertions u_assert (
    .clk_74a   (clk_74a),
    .rst       (rst),
    .sclk_fall (i2s.sclk_fall),
    .lrck      (i2s.lrck),
    .dac       (i2s.dac)
);

`default_nettype wire

/* core_top.sv */
// core top level, single clk_74a domain with synchronous active high rst
// mode selection, bridge read mux and I2S silence generator
// video, PLL and the command handler live outside, mode leaves as a port
`timescale 1ns/1ns
`default_nettype none

module core_top #(
    parameter logic [core_pkg::ACCUM_W-1:0] MCLK_STEP    = core_pkg::MCLK_STEP,
    parameter logic [core_pkg::ACCUM_W-1:0] MCLK_MODULUS = core_pkg::MCLK_MODULUS,
    parameter int                           SLOT_BITS    = core_pkg::SLOT_BITS
) (
    input  wire             clk_74a,
    input  wire             rst,

    // controller 1, bit 0 is d-pad up
    input  wire  [31:0]     cont1_key,

    // bridge bus, synchronous to clk_74a
    input  wire  [31:0]     bridge_addr,
    input  wire             bridge_rd,
    input  wire  [31:0]     cmd_rd_data,
    output logic [31:0]     bridge_rd_data,

    // display mode to the video side
    output core_pkg::mode_t mode,

    // audio
    output logic            audio_mclk,
    output logic            audio_sclk,
    output logic            audio_lrck,
    output logic            audio_dac
);

    ////////////////////////////////////////////////////////////
    // mode select and bridge readback

    mode_select u_mode (
        .clk_74a (clk_74a),
        .rst     (rst),
        .key_up  (cont1_key[0]),
        .mode    (mode)
    );

    bridge_read_mux u_bridge (
        .clk_74a        (clk_74a),
        .rst            (rst),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .mode           (mode),
        .cmd_rd_data    (cmd_rd_data),
        .bridge_rd_data (bridge_rd_data)
    );

    ////////////////////////////////////////////////////////////
    // I2S silence generator

    i2s_if i2s ();

    audio_clock_gen #(
        .STEP    (MCLK_STEP),
        .MODULUS (MCLK_MODULUS)
    ) u_clkgen (
        .clk_74a (clk_74a),
        .rst     (rst),
        .i2s     (i2s.gen)
    );

    i2s_frame #(
        .SLOT_BITS (SLOT_BITS)
    ) u_frame (
        .clk_74a (clk_74a),
        .rst     (rst),
        .i2s     (i2s.frame)
    );

    // audio pins straight from the bundle
    assign audio_mclk = i2s.mclk;
    assign audio_sclk = i2s.sclk;
    assign audio_lrck = i2s.lrck;
    assign audio_dac  = i2s.dac;

endmodule

`default_nettype wire

/* i2s_frame.sv */
// I2S framing, lrck toggles every SLOT_BITS sclk periods
// SLOT_BITS must be a power of two, the slot counter wraps by overflow
// silence only, dac is held low
`timescale 1ns/1ns
`default_nettype none

module i2s_frame #(
    parameter int SLOT_BITS = core_pkg::SLOT_BITS
) (
    input  wire  clk_74a,
    input  wire  rst,
    i2s_if.frame i2s
);

    localparam int CNT_W = $clog2(SLOT_BITS);

    // bit position within the current channel slot
    logic [CNT_W-1:0] bit_cnt;
    logic             lrck_q;
    logic             last_bit;

    assign last_bit = (bit_cnt == CNT_W'(SLOT_BITS - 1));

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            bit_cnt <= '0;
            lrck_q  <= 1'b0;
        end else if (i2s.sclk_fall) begin
            bit_cnt <= bit_cnt + 1'b1;
            // end of slot, switch channel
            if (last_bit) begin
                lrck_q <= ~lrck_q;
            end
        end
    end

    assign i2s.lrck = lrck_q;
    // no sample source, shift out zeros
    assign i2s.dac  = 1'b0;

endmodule

`default_nettype wire

/* audio_clock_gen.sv */
// mclk and sclk regenerated as levels in clk_74a from a fractional accumulator
// STEP + MODULUS must fit in ACCUM_W bits, and STEP below MODULUS / 2
// sclk = mclk / 4, sclk_fall marks the clk_74a cycle where sclk drops
`timescale 1ns/1ns
`default_nettype none

module audio_clock_gen #(
    parameter logic [core_pkg::ACCUM_W-1:0] STEP    = core_pkg::MCLK_STEP,
    parameter logic [core_pkg::ACCUM_W-1:0] MODULUS = core_pkg::MCLK_MODULUS
) (
    input  wire clk_74a,
    input  wire rst,
    i2s_if.gen  i2s
);

    import core_pkg::*;

    ////////////////////////////////////////////////////////////
    // fractional accumulator

    logic [ACCUM_W-1:0] accum;
    logic [ACCUM_W-1:0] accum_sum;
    // sum reached the modulus, mclk edge this clock
    logic               mclk_tick;
    logic               mclk_q;

    assign accum_sum = accum + STEP;
    assign mclk_tick = (accum_sum >= MODULUS);

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            accum  <= '0;
            mclk_q <= 1'b0;
        end else if (mclk_tick) begin
            // keep the remainder so the average rate is exact
            accum  <= accum_sum - MODULUS;
            mclk_q <= ~mclk_q;
        end else begin
            accum  <= accum_sum;
        end
    end

    ////////////////////////////////////////////////////////////
    // mclk divider and sclk falling strobe

    logic [1:0] div;
    logic       mclk_rise;
    logic       sclk_fall_q;

    // tick while mclk is low means it goes high at this edge
    assign mclk_rise = mclk_tick & ~mclk_q;

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            div         <= 2'd0;
            sclk_fall_q <= 1'b0;
        end else begin
            // 3 -> 0 on this rise drops div[1], so flag it now
            sclk_fall_q <= mclk_rise & (div == 2'd3);
            if (mclk_rise) begin
                div <= div + 2'd1;
            end
        end
    end

    assign i2s.mclk      = mclk_q;
    assign i2s.sclk      = div[1];
    assign i2s.sclk_fall = sclk_fall_q;

endmodule

`default_nettype wire

/* bridge_read_mux.sv */
// bridge read data mux, decoded by the top address byte
// read data appears one clock after the bridge_rd strobe and holds until the next
// unmapped regions return zero
`timescale 1ns/1ns
`default_nettype none

module bridge_read_mux (
    input  wire             clk_74a,
    input  wire             rst,
    input  wire  [31:0]     bridge_addr,
    input  wire             bridge_rd,
    input  wire core_pkg::mode_t mode,
    input  wire  [31:0]     cmd_rd_data,
    output logic [31:0]     bridge_rd_data
);

    import core_pkg::*;

    // region select byte
    logic [7:0] region;

    assign region = bridge_addr[31:24];

    ////////////////////////////////////////////////////////////
    // registered read path

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            bridge_rd_data <= '0;
        end else if (bridge_rd) begin
            case (region)
                // mode readback, zero-extended
                REGION_MODE: bridge_rd_data <= 32'(mode);
                // command handler space
                REGION_CMD:  bridge_rd_data <= cmd_rd_data;
                // nothing mapped here
                default:     bridge_rd_data <= '0;
            endcase
        end
        // no strobe, hold last value
    end

endmodule

`default_nettype wire

/* mode_select.sv */
// display mode select from the d-pad up key
// key is assumed already synchronous to clk_74a
`timescale 1ns/1ns
`default_nettype none

module mode_select (
    input  wire            clk_74a,
    input  wire            rst,
    input  wire            key_up,
    output core_pkg::mode_t mode
);

    // previous key sample for edge detect
    logic key_q;
    logic key_rise;

    // high now, low on the previous clock
    assign key_rise = key_up & ~key_q;

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            key_q <= 1'b0;
            mode  <= '0;
        end else begin
            key_q <= key_up;
            // one step per press, holding the key does nothing
            if (key_rise) begin
                // 2-bit add wraps 3 -> 0 on its own
                mode <= mode + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* i2s_if.sv */
// I2S signal bundle between the clock generator and the frame logic
// all signals are levels or strobes sampled in clk_74a, no clock of their own
`timescale 1ns/1ns
`default_nettype none

interface i2s_if;

    // regenerated audio clocks as registered levels
    logic mclk;
    logic sclk;
    // one clk_74a cycle wide, same cycle sclk goes low
    logic sclk_fall;

    // frame side
    logic lrck;
    logic dac;

    // clock generator drives mclk, sclk and the falling strobe
    modport gen (
        output mclk,
        output sclk,
        output sclk_fall
    );

    // frame logic steps on sclk_fall only
    modport frame (
        input  sclk_fall,
        output lrck,
        output dac
    );

endinterface

`default_nettype wire

/* core_pkg.sv */
// shared constants for the core: audio timing, bridge regions, display mode
// MCLK_STEP + MCLK_MODULUS must fit in ACCUM_W bits, step/modulus below one half
// SLOT_BITS must be a power of two
`default_nettype none

package core_pkg;

    ////////////////////////////////////////////////////////////
    // display mode

    // 2-bit mode, wraps from 3 back to 0
    typedef logic [1:0] mode_t;

    ////////////////////////////////////////////////////////////
    // audio timing

    // accumulator width for the fractional mclk generator
    localparam int ACCUM_W = 22;

    // 74.25 MHz * 245760 / 742500 / 2 = 12.288 MHz mclk on average
    localparam logic [ACCUM_W-1:0] MCLK_STEP    = 22'd245760;
    localparam logic [ACCUM_W-1:0] MCLK_MODULUS = 22'd742500;

    // sclk periods per channel slot, 64 per frame at 48 kHz
    localparam int SLOT_BITS = 32;

    ////////////////////////////////////////////////////////////
    // bridge address map, top address byte

    localparam logic [7:0] REGION_MODE = 8'h10;
    localparam logic [7:0] REGION_CMD  = 8'hF8;

endpackage

`default_nettype wire
